//--- rtl/quplsPkg.sv
`default_nettype none

package quplsPkg;

	// ========================================
	// Instruction word layout
	// ========================================

	// Every instruction seen by this decoder is a single 32-bit word
	localparam int InstrWidth = 32;

	// Field boundaries inside the instruction word
	localparam int OpcodeLsb = 0;
	localparam int OpcodeMsb = 6;
	localparam int RtLsb = 7;
	localparam int RtMsb = 11;
	localparam int RaLsb = 12;
	localparam int RaMsb = 16;
	localparam int RbLsb = 17;
	localparam int RbMsb = 21;
	localparam int SwapBit = 22;
	localparam int ImmLsb = 23;
	localparam int ImmMsb = 31;

	// Derived field widths
	localparam int RegWidth = RtMsb - RtLsb + 1;
	localparam int ImmWidth = ImmMsb - ImmLsb + 1;

	// Defaults that the top level hands down unless overridden
	localparam int DefaultDataWidth = 64;
	localparam int DefaultQueueDepth = 4;

	// ========================================
	// Encodings
	// ========================================

	// Primary opcodes, any value not listed here decodes as illegal
	typedef enum logic [6:0] {
		OP_NOP = 7'h00,
		OP_ADD = 7'h04, OP_SUB = 7'h05, OP_AND = 7'h08, OP_OR = 7'h09, OP_EOR = 7'h0A,
		OP_ADDI = 7'h14, OP_SUBFI = 7'h15, OP_CMPI = 7'h16, OP_MULI = 7'h17,
		OP_DIVI = 7'h18, OP_SLTI = 7'h19, OP_ANDI = 7'h1A, OP_ORI = 7'h1B, OP_EORI = 7'h1C,
		OP_JSR = 7'h20,
		OP_LDB = 7'h40, OP_LDBU = 7'h41, OP_LDW = 7'h42, OP_LDWU = 7'h43,
		OP_LDT = 7'h44, OP_LDTU = 7'h45, OP_LDO = 7'h46, OP_LDA = 7'h47,
		OP_CACHE = 7'h48,
		OP_STB = 7'h50, OP_STW = 7'h51, OP_STT = 7'h52, OP_STO = 7'h53
	} opcodeE;

	// Operation requested from the integer ALU
	typedef enum logic [3:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_CMP, ALU_MUL,
		ALU_DIV, ALU_SLT, ALU_AND, ALU_OR, ALU_EOR
	} aluOpE;

	// Kind of memory access, if any
	typedef enum logic [1:0] {
		MEM_NONE, MEM_LOAD, MEM_STORE, MEM_CACHE
	} memOpE;

	// Access size: byte, wyde (16), tetra (32) and octa (64)
	typedef enum logic [1:0] {
		SZ_BYTE, SZ_WYDE, SZ_TETRA, SZ_OCTA
	} memSizeE;

endpackage

`default_nettype wire

//--- rtl/quplsDecodeSwap.sv
`default_nettype none

module quplsDecodeSwap
(
	input  wire [quplsPkg::InstrWidth-1:0] instr,
	output logic swap
);

	quplsPkg::opcodeE opcode;

	// View the low bits of the word as an opcode
	assign opcode = quplsPkg::opcodeE'(instr[quplsPkg::OpcodeMsb:quplsPkg::OpcodeLsb]);

	// Only forms carrying an immediate may exchange their operands
	// When set, operand A becomes the immediate and operand B becomes Ra
	always_comb
	begin
		case (opcode)
			// Immediate ALU forms
			quplsPkg::OP_ADDI, quplsPkg::OP_SUBFI, quplsPkg::OP_CMPI, quplsPkg::OP_MULI,
			quplsPkg::OP_DIVI, quplsPkg::OP_SLTI, quplsPkg::OP_ANDI, quplsPkg::OP_ORI,
			quplsPkg::OP_EORI:
				swap = instr[quplsPkg::SwapBit];
			// Subroutine call computes its target from Ra plus displacement
			quplsPkg::OP_JSR:
				swap = instr[quplsPkg::SwapBit];
			// Memory forms, address is Ra plus displacement
			quplsPkg::OP_LDB, quplsPkg::OP_LDBU, quplsPkg::OP_LDW, quplsPkg::OP_LDWU,
			quplsPkg::OP_LDT, quplsPkg::OP_LDTU, quplsPkg::OP_LDO, quplsPkg::OP_LDA,
			quplsPkg::OP_CACHE,
			quplsPkg::OP_STB, quplsPkg::OP_STW, quplsPkg::OP_STT, quplsPkg::OP_STO:
				swap = instr[quplsPkg::SwapBit];
			// Register forms and illegal codes ignore bit 22
			default:
				swap = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/quplsDecodeImm.sv
`default_nettype none

module quplsDecodeImm
#(
	parameter int DataWidth = quplsPkg::DefaultDataWidth
)
(
	input  wire [quplsPkg::InstrWidth-1:0] instr,
	output logic [DataWidth-1:0] imm,
	output logic hasImm
);

	quplsPkg::opcodeE opcode;
	logic [quplsPkg::ImmWidth-1:0] immField;

	assign opcode = quplsPkg::opcodeE'(instr[quplsPkg::OpcodeMsb:quplsPkg::OpcodeLsb]);
	assign immField = instr[quplsPkg::ImmMsb:quplsPkg::ImmLsb];

	// The immediate forms are the same set that may swap operands
	always_comb
	begin
		case (opcode)
			quplsPkg::OP_ADDI, quplsPkg::OP_SUBFI, quplsPkg::OP_CMPI, quplsPkg::OP_MULI,
			quplsPkg::OP_DIVI, quplsPkg::OP_SLTI, quplsPkg::OP_ANDI, quplsPkg::OP_ORI,
			quplsPkg::OP_EORI,
			quplsPkg::OP_JSR,
			quplsPkg::OP_LDB, quplsPkg::OP_LDBU, quplsPkg::OP_LDW, quplsPkg::OP_LDWU,
			quplsPkg::OP_LDT, quplsPkg::OP_LDTU, quplsPkg::OP_LDO, quplsPkg::OP_LDA,
			quplsPkg::OP_CACHE,
			quplsPkg::OP_STB, quplsPkg::OP_STW, quplsPkg::OP_STT, quplsPkg::OP_STO:
				hasImm = 1'b1;
			default:
				hasImm = 1'b0;
		endcase
	end

	// Replicate bit 31 up to the full data width
	// A word without an immediate reports zero so that later stages see a clean value
	always_comb
	begin
		if (hasImm)
			imm = {{(DataWidth - quplsPkg::ImmWidth){immField[quplsPkg::ImmWidth-1]}}, immField};
		else
			imm = '0;
	end

endmodule

`default_nettype wire

//--- rtl/quplsDecodeOp.sv
`default_nettype none

module quplsDecodeOp
(
	input  wire [quplsPkg::InstrWidth-1:0] instr,
	output quplsPkg::aluOpE aluOp,
	output quplsPkg::memOpE memOp,
	output quplsPkg::memSizeE memSize,
	output logic loadUnsigned,
	output logic illegal
);

	quplsPkg::opcodeE opcode;

	assign opcode = quplsPkg::opcodeE'(instr[quplsPkg::OpcodeMsb:quplsPkg::OpcodeLsb]);

	always_comb
	begin
		// Start from the quiet decode and let each opcode override what it needs
		aluOp = quplsPkg::ALU_NONE;
		memOp = quplsPkg::MEM_NONE;
		memSize = quplsPkg::SZ_BYTE;
		loadUnsigned = 1'b0;
		illegal = 1'b0;
		case (opcode)
			quplsPkg::OP_NOP: ;

			// ========================================
			// Register and immediate ALU forms
			// ========================================
			quplsPkg::OP_ADD, quplsPkg::OP_ADDI: aluOp = quplsPkg::ALU_ADD;
			// Subtract-from uses the plain subtractor and swap sets the operand order
			quplsPkg::OP_SUB, quplsPkg::OP_SUBFI: aluOp = quplsPkg::ALU_SUB;
			quplsPkg::OP_CMPI: aluOp = quplsPkg::ALU_CMP;
			quplsPkg::OP_MULI: aluOp = quplsPkg::ALU_MUL;
			quplsPkg::OP_DIVI: aluOp = quplsPkg::ALU_DIV;
			quplsPkg::OP_SLTI: aluOp = quplsPkg::ALU_SLT;
			quplsPkg::OP_AND, quplsPkg::OP_ANDI: aluOp = quplsPkg::ALU_AND;
			quplsPkg::OP_OR, quplsPkg::OP_ORI: aluOp = quplsPkg::ALU_OR;
			quplsPkg::OP_EOR, quplsPkg::OP_EORI: aluOp = quplsPkg::ALU_EOR;

			// ========================================
			// Address forms
			// ========================================
			// JSR and LDA only form an address and never touch memory
			quplsPkg::OP_JSR, quplsPkg::OP_LDA: aluOp = quplsPkg::ALU_ADD;
			quplsPkg::OP_LDB, quplsPkg::OP_LDBU, quplsPkg::OP_LDW, quplsPkg::OP_LDWU,
			quplsPkg::OP_LDT, quplsPkg::OP_LDTU, quplsPkg::OP_LDO:
			begin
				aluOp = quplsPkg::ALU_ADD;
				memOp = quplsPkg::MEM_LOAD;
				// Sizes step every two codes
				memSize = quplsPkg::memSizeE'(opcode[2:1]);
				// The odd code of each pair is the unsigned load
				loadUnsigned = opcode[0];
			end
			quplsPkg::OP_STB, quplsPkg::OP_STW, quplsPkg::OP_STT, quplsPkg::OP_STO:
			begin
				aluOp = quplsPkg::ALU_ADD;
				memOp = quplsPkg::MEM_STORE;
				// Store sizes run in code order
				memSize = quplsPkg::memSizeE'(opcode[1:0]);
			end
			// Cache operations act on a whole line and report octa
			quplsPkg::OP_CACHE:
			begin
				aluOp = quplsPkg::ALU_ADD;
				memOp = quplsPkg::MEM_CACHE;
				memSize = quplsPkg::SZ_OCTA;
			end
			default:
				illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/quplsInstrQueue.sv
`default_nettype none

module quplsInstrQueue
#(
	parameter int QueueDepth = quplsPkg::DefaultQueueDepth
)
(
	input  wire clk,
	input  wire rst,
	input  wire inValid,
	output logic inReady,
	input  wire [quplsPkg::InstrWidth-1:0] inInstr,
	output logic qValid,
	input  wire qReady,
	output logic [quplsPkg::InstrWidth-1:0] qInstr
);

	// Depth is a power of two so the pointers simply wrap
	localparam int PtrWidth = $clog2(QueueDepth);
	localparam int CountWidth = $clog2(QueueDepth + 1);

	logic [quplsPkg::InstrWidth-1:0] slots [QueueDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	logic push;
	logic pop;

	// Fetch may write whenever a slot is free
	assign inReady = count != CountWidth'(QueueDepth);
	assign qValid = count != '0;
	// The oldest word is always presented at the read pointer
	assign qInstr = slots[rdPtr];
	assign push = inValid && inReady;
	assign pop = qValid && qReady;

	always_ff @(posedge clk)
	begin
		if (push)
			slots[wrPtr] <= inInstr;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + PtrWidth'(1);
			if (pop)
				rdPtr <= rdPtr + PtrWidth'(1);
			// A push and a pop together leave the occupancy unchanged
			if (push && !pop)
				count <= count + CountWidth'(1);
			else if (pop && !push)
				count <= count - CountWidth'(1);
		end
	end

endmodule

`default_nettype wire

//--- rtl/quplsDecodeStage.sv
`default_nettype none

module quplsDecodeStage
#(
	parameter int DataWidth = quplsPkg::DefaultDataWidth
)
(
	input  wire clk,
	input  wire rst,
	input  wire qValid,
	output logic qReady,
	input  wire [quplsPkg::InstrWidth-1:0] qInstr,
	output logic outValid,
	input  wire outReady,
	output logic [quplsPkg::RegWidth-1:0] rt,
	output logic [quplsPkg::RegWidth-1:0] ra,
	output logic [quplsPkg::RegWidth-1:0] rb,
	output logic [DataWidth-1:0] imm,
	output logic hasImm,
	output logic swap,
	output quplsPkg::aluOpE aluOp,
	output quplsPkg::memOpE memOp,
	output quplsPkg::memSizeE memSize,
	output logic loadUnsigned,
	output logic illegal
);

	logic take;
	logic decSwap;
	logic [DataWidth-1:0] decImm;
	logic decHasImm;
	quplsPkg::aluOpE decAluOp;
	quplsPkg::memOpE decMemOp;
	quplsPkg::memSizeE decMemSize;
	logic decLoadUnsigned;
	logic decIllegal;

	// ========================================
	// Combinational decode of the queue head
	// ========================================
	quplsDecodeSwap quplsDecodeSwap_i (.instr(qInstr), .swap(decSwap));

	quplsDecodeImm #(.DataWidth(DataWidth)) quplsDecodeImm_i
	(
		.instr(qInstr),
		.imm(decImm),
		.hasImm(decHasImm)
	);

	quplsDecodeOp quplsDecodeOp_i
	(
		.instr(qInstr),
		.aluOp(decAluOp),
		.memOp(decMemOp),
		.memSize(decMemSize),
		.loadUnsigned(decLoadUnsigned),
		.illegal(decIllegal)
	);

	// ========================================
	// Output register
	// ========================================
	// The register can refill when empty or when its word leaves this cycle
	assign qReady = !outValid || outReady;
	assign take = qValid && qReady;

	always_ff @(posedge clk)
	begin
		if (rst)
			outValid <= 1'b0;
		else if (take)
			outValid <= 1'b1;
		// Drained with nothing behind it
		else if (outReady)
			outValid <= 1'b0;
	end

	// Payload only changes on a take, so it holds steady while stalled
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			rt <= qInstr[quplsPkg::RtMsb:quplsPkg::RtLsb];
			ra <= qInstr[quplsPkg::RaMsb:quplsPkg::RaLsb];
			rb <= qInstr[quplsPkg::RbMsb:quplsPkg::RbLsb];
			imm <= decImm;
			hasImm <= decHasImm;
			swap <= decSwap;
			aluOp <= decAluOp;
			memOp <= decMemOp;
			memSize <= decMemSize;
			loadUnsigned <= decLoadUnsigned;
			illegal <= decIllegal;
		end
	end

endmodule

`default_nettype wire

//--- rtl/quplsDecodeTop.sv
`default_nettype none

module quplsDecodeTop
#(
	parameter int DataWidth = quplsPkg::DefaultDataWidth,
	parameter int QueueDepth = quplsPkg::DefaultQueueDepth
)
(
	input  wire clk,
	input  wire rst,
	input  wire inValid,
	output logic inReady,
	input  wire [quplsPkg::InstrWidth-1:0] inInstr,
	input  wire outReady,
	output logic outValid,
	output logic [quplsPkg::RegWidth-1:0] rt,
	output logic [quplsPkg::RegWidth-1:0] ra,
	output logic [quplsPkg::RegWidth-1:0] rb,
	output logic [DataWidth-1:0] imm,
	output logic hasImm,
	output logic swap,
	output quplsPkg::aluOpE aluOp,
	output quplsPkg::memOpE memOp,
	output quplsPkg::memSizeE memSize,
	output logic loadUnsigned,
	output logic illegal
);

	// Handshake between the queue head and the decode register
	logic qValid;
	logic qReady;
	logic [quplsPkg::InstrWidth-1:0] qInstr;

	quplsInstrQueue #(.QueueDepth(QueueDepth)) quplsInstrQueue_i
	(
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.qValid(qValid),
		.qReady(qReady),
		.qInstr(qInstr)
	);

	// One more word can wait in the decode register beyond the queue depth
	quplsDecodeStage #(.DataWidth(DataWidth)) quplsDecodeStage_i
	(
		.clk(clk),
		.rst(rst),
		.qValid(qValid),
		.qReady(qReady),
		.qInstr(qInstr),
		.outValid(outValid),
		.outReady(outReady),
		.rt(rt),
		.ra(ra),
		.rb(rb),
		.imm(imm),
		.hasImm(hasImm),
		.swap(swap),
		.aluOp(aluOp),
		.memOp(memOp),
		.memSize(memSize),
		.loadUnsigned(loadUnsigned),
		.illegal(illegal)
	);

endmodule

`default_nettype wire

//--- testbench/quplsDecodeTb.sv
`default_nettype none

module quplsDecodeTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DataWidth = quplsPkg::DefaultDataWidth;
	localparam int QueueDepth = quplsPkg::DefaultQueueDepth;

	// Stimulus categories, CatMix draws from the others and CatAny is the raw 7-bit range
	localparam int CatReg = 0;
	localparam int CatImm = 1;
	localparam int CatMem = 2;
	localparam int CatIllegal = 3;
	localparam int CatMix = 4;
	localparam int CatAny = 5;

	// One decoded result, in the same shape as the DUT outputs
	typedef struct packed {
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [DataWidth-1:0] imm;
		logic hasImm;
		logic swap;
		quplsPkg::aluOpE aluOp;
		quplsPkg::memOpE memOp;
		quplsPkg::memSizeE memSize;
		logic loadUnsigned;
		logic illegal;
	} decodedT;

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	logic inReady;
	logic [31:0] inInstr;
	logic outReady;
	logic outValid;
	logic [4:0] rt;
	logic [4:0] ra;
	logic [4:0] rb;
	logic [DataWidth-1:0] imm;
	logic hasImm;
	logic swap;
	quplsPkg::aluOpE aluOp;
	quplsPkg::memOpE memOp;
	quplsPkg::memSizeE memSize;
	logic loadUnsigned;
	logic illegal;

	// Words accepted by the DUT and not yet seen at its output, oldest first
	logic [31:0] sb [$];
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;

	// Legal opcode groups used to build instruction words
	quplsPkg::opcodeE regOps [$] = '{quplsPkg::OP_NOP, quplsPkg::OP_ADD, quplsPkg::OP_SUB,
		quplsPkg::OP_AND, quplsPkg::OP_OR, quplsPkg::OP_EOR};
	quplsPkg::opcodeE immOps [$] = '{quplsPkg::OP_ADDI, quplsPkg::OP_SUBFI, quplsPkg::OP_CMPI,
		quplsPkg::OP_MULI, quplsPkg::OP_DIVI, quplsPkg::OP_SLTI, quplsPkg::OP_ANDI,
		quplsPkg::OP_ORI, quplsPkg::OP_EORI, quplsPkg::OP_JSR};
	quplsPkg::opcodeE memOps [$] = '{quplsPkg::OP_LDB, quplsPkg::OP_LDBU, quplsPkg::OP_LDW,
		quplsPkg::OP_LDWU, quplsPkg::OP_LDT, quplsPkg::OP_LDTU, quplsPkg::OP_LDO,
		quplsPkg::OP_LDA, quplsPkg::OP_CACHE, quplsPkg::OP_STB, quplsPkg::OP_STW,
		quplsPkg::OP_STT, quplsPkg::OP_STO};

	quplsDecodeTop #(.DataWidth(DataWidth), .QueueDepth(QueueDepth)) quplsDecodeTop_i
	(
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.outReady(outReady),
		.outValid(outValid),
		.rt(rt),
		.ra(ra),
		.rb(rb),
		.imm(imm),
		.hasImm(hasImm),
		.swap(swap),
		.aluOp(aluOp),
		.memOp(memOp),
		.memSize(memSize),
		.loadUnsigned(loadUnsigned),
		.illegal(illegal)
	);

	always #10 clk = ~clk;

	// ========================================
	// Reference decode model
	// ========================================
	function automatic decodedT decodeModel(logic [31:0] instr);
		decodedT d;
		logic immForm;
		begin
			d = '0;
			immForm = 1'b0;
			// Register fields are passed through for every opcode
			d.rt = instr[11:7];
			d.ra = instr[16:12];
			d.rb = instr[21:17];
			// Immediate ALU forms, JSR and every memory form carry an immediate
			case (instr[6:0])
				7'h14, 7'h15, 7'h16, 7'h17, 7'h18, 7'h19, 7'h1A, 7'h1B, 7'h1C, 7'h20,
				7'h40, 7'h41, 7'h42, 7'h43, 7'h44, 7'h45, 7'h46, 7'h47, 7'h48,
				7'h50, 7'h51, 7'h52, 7'h53: immForm = 1'b1;
				default: immForm = 1'b0;
			endcase
			case (instr[6:0])
				7'h00, 7'h04, 7'h05, 7'h08, 7'h09, 7'h0A: d.illegal = 1'b0;
				default: d.illegal = !immForm;
			endcase
			// Address computations all go through the adder
			case (instr[6:0])
				7'h04, 7'h14, 7'h20, 7'h40, 7'h41, 7'h42, 7'h43, 7'h44, 7'h45, 7'h46,
				7'h47, 7'h48, 7'h50, 7'h51, 7'h52, 7'h53: d.aluOp = quplsPkg::ALU_ADD;
				7'h05, 7'h15: d.aluOp = quplsPkg::ALU_SUB;
				7'h16: d.aluOp = quplsPkg::ALU_CMP;
				7'h17: d.aluOp = quplsPkg::ALU_MUL;
				7'h18: d.aluOp = quplsPkg::ALU_DIV;
				7'h19: d.aluOp = quplsPkg::ALU_SLT;
				7'h08, 7'h1A: d.aluOp = quplsPkg::ALU_AND;
				7'h09, 7'h1B: d.aluOp = quplsPkg::ALU_OR;
				7'h0A, 7'h1C: d.aluOp = quplsPkg::ALU_EOR;
				default: d.aluOp = quplsPkg::ALU_NONE;
			endcase
			// LDA and JSR form an address but never touch memory
			case (instr[6:0])
				7'h40, 7'h41, 7'h42, 7'h43, 7'h44, 7'h45, 7'h46: d.memOp = quplsPkg::MEM_LOAD;
				7'h50, 7'h51, 7'h52, 7'h53: d.memOp = quplsPkg::MEM_STORE;
				7'h48: d.memOp = quplsPkg::MEM_CACHE;
				default: d.memOp = quplsPkg::MEM_NONE;
			endcase
			case (instr[6:0])
				7'h42, 7'h43, 7'h51: d.memSize = quplsPkg::SZ_WYDE;
				7'h44, 7'h45, 7'h52: d.memSize = quplsPkg::SZ_TETRA;
				7'h46, 7'h48, 7'h53: d.memSize = quplsPkg::SZ_OCTA;
				default: d.memSize = quplsPkg::SZ_BYTE;
			endcase
			d.loadUnsigned = instr[6:0] == 7'h41 || instr[6:0] == 7'h43 || instr[6:0] == 7'h45;
			d.hasImm = immForm;
			d.swap = immForm && instr[22];
			if (immForm)
				d.imm = {{(DataWidth - 9){instr[31]}}, instr[31:23]};
			return d;
		end
	endfunction

	// Random word whose opcode comes from the requested category
	function automatic logic [31:0] makeWord(int cat);
		logic [31:0] w;
		decodedT d;
		int c;
		begin
			w = $urandom;
			c = cat;
			if (c == CatMix)
				c = ($urandom_range(7) == 0) ? CatAny : int'($urandom_range(2));
			case (c)
				CatReg: w[6:0] = regOps[$urandom_range(regOps.size() - 1)];
				CatImm: w[6:0] = immOps[$urandom_range(immOps.size() - 1)];
				CatMem: w[6:0] = memOps[$urandom_range(memOps.size() - 1)];
				CatIllegal:
				begin
					d = decodeModel(w);
					// Redraw until the model rejects the opcode
					while (!d.illegal)
					begin
						w[6:0] = 7'($urandom_range(127));
						d = decodeModel(w);
					end
				end
				default: w[6:0] = 7'($urandom_range(127));
			endcase
			return w;
		end
	endfunction

	// ========================================
	// Compare tasks
	// ========================================
	task automatic checkReg(string name, logic [4:0] got, logic [4:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkImm(string name, logic [DataWidth-1:0] got, logic [DataWidth-1:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkAluOp(string name, quplsPkg::aluOpE got, quplsPkg::aluOpE exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkMemOp(string name, quplsPkg::memOpE got, quplsPkg::memOpE exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkMemSize(string name, quplsPkg::memSizeE got, quplsPkg::memSizeE exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	// Compares every decoded output of the DUT with one expected result
	task automatic checkAll(decodedT exp, string tag);
		checkReg({tag, "rt"}, rt, exp.rt);
		checkReg({tag, "ra"}, ra, exp.ra);
		checkReg({tag, "rb"}, rb, exp.rb);
		checkImm({tag, "imm"}, imm, exp.imm);
		checkFlag({tag, "hasImm"}, hasImm, exp.hasImm);
		checkFlag({tag, "swap"}, swap, exp.swap);
		checkAluOp({tag, "aluOp"}, aluOp, exp.aluOp);
		checkMemOp({tag, "memOp"}, memOp, exp.memOp);
		checkMemSize({tag, "memSize"}, memSize, exp.memSize);
		checkFlag({tag, "loadUnsigned"}, loadUnsigned, exp.loadUnsigned);
		checkFlag({tag, "illegal"}, illegal, exp.illegal);
	endtask

	function automatic decodedT captureOutputs();
		decodedT d;
		begin
			d.rt = rt;
			d.ra = ra;
			d.rb = rb;
			d.imm = imm;
			d.hasImm = hasImm;
			d.swap = swap;
			d.aluOp = aluOp;
			d.memOp = memOp;
			d.memSize = memSize;
			d.loadUnsigned = loadUnsigned;
			d.illegal = illegal;
			return d;
		end
	endfunction

	// ========================================
	// Test sequencing
	// ========================================
	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		inValid <= 1'b0;
		outReady <= 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		sb.delete();
	endtask

	task automatic reportTest(string name, int startErrors);
		testCount++;
		if (errorCount != startErrors)
			failedTests++;
		$display("test %0d %s: %s with %0d errors", testCount, name,
			(errorCount == startErrors) ? "pass" : "fail", errorCount - startErrors);
	endtask

	// Streams count words of one category and checks every result in order
	// Inputs change on rising edges, all sampling happens on falling edges
	task automatic runTest(string name, int cat, int count, bit backPressure);
		decodedT snap;
		int generated;
		int cycles;
		int startErrors;
		bit pending;
		bit accept;
		bit stalled;
		bit timedOut;
		generated = 0;
		cycles = 0;
		startErrors = errorCount;
		pending = 1'b0;
		accept = 1'b0;
		stalled = 1'b0;
		timedOut = 1'b0;
		snap = '0;
		while (generated < count || pending || sb.size() != 0)
		begin
			@(posedge clk);
			if (accept)
				pending = 1'b0;
			// A word stays on the bus until the DUT takes it
			if (!pending && generated < count && $urandom_range(3) != 0)
			begin
				inInstr <= makeWord(cat);
				inValid <= 1'b1;
				pending = 1'b1;
				generated++;
			end
			else if (!pending)
				inValid <= 1'b0;
			outReady <= backPressure ? ($urandom_range(2) == 0) : 1'b1;

			@(negedge clk);
			// A stalled result must not change until it is taken
			if (stalled)
			begin
				checkFlag("held outValid", outValid, 1'b1);
				checkAll(snap, "held ");
			end
			// The queue plus the decode register hold QueueDepth+1 words
			checkFlag("inReady", inReady, sb.size() != QueueDepth + 1);
			accept = inValid && inReady;
			if (outValid && outReady)
			begin
				if (sb.size() == 0)
				begin
					$display("test %s: the DUT delivered a word that was never sent", name);
					errorCount++;
				end
				else
					checkAll(decodeModel(sb.pop_front()), "");
			end
			if (accept)
				sb.push_back(inInstr);
			stalled = outValid && !outReady;
			if (stalled)
				snap = captureOutputs();
			cycles++;
			if (cycles > count * 20 + 100)
			begin
				$display("test %s: timed out after %0d cycles with %0d words outstanding",
					name, cycles, sb.size());
				errorCount++;
				timedOut = 1'b1;
				break;
			end
		end
		if (timedOut)
			applyReset();
		else
		begin
			@(negedge clk);
			checkFlag("drained outValid", outValid, 1'b0);
		end
		reportTest(name, startErrors);
	endtask

	initial
	begin
		int startErrors;
		void'($urandom(32'hf4ae));
		rst <= 1'b1;
		inValid <= 1'b0;
		inInstr <= '0;
		outReady <= 1'b1;
		applyReset();

		// Idle state straight out of reset
		startErrors = errorCount;
		@(negedge clk);
		checkFlag("outValid", outValid, 1'b0);
		checkFlag("inReady", inReady, 1'b1);
		reportTest("reset state", startErrors);

		runTest("register forms", CatReg, 64, 1'b0);
		runTest("immediate forms and JSR", CatImm, 96, 1'b0);
		runTest("memory forms", CatMem, 128, 1'b0);
		runTest("illegal opcodes", CatIllegal, 64, 1'b0);
		runTest("mixed traffic under back-pressure", CatMix, 400, 1'b1);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, checkCount, errorCount);
		if (failedTests == 0 && errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- quplsDecodeTop.f
rtl/quplsPkg.sv
rtl/quplsDecodeSwap.sv
rtl/quplsDecodeImm.sv
rtl/quplsDecodeOp.sv
rtl/quplsInstrQueue.sv
rtl/quplsDecodeStage.sv
rtl/quplsDecodeTop.sv
testbench/quplsDecodeTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the decode testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f quplsDecodeTop.f \
	--top-module quplsDecodeTb \
	-o quplsDecodeSim

./obj_dir/quplsDecodeSim > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
